// File: compile.f
bip_isa_pkg.sv
uart_pkg.sv
bip_cpu.sv
bip_program_memory.sv
bip_data_memory.sv
uart_baud_gen.sv
uart_rx.sv
uart_tx.sv
bip_debug_interface.sv
bip_top.sv
tb_bip_top.sv

// File: Bender.yml
package:
  name: bip_uart_debug

sources:
  - bip_isa_pkg.sv
  - uart_pkg.sv
  - bip_cpu.sv
  - bip_program_memory.sv
  - bip_data_memory.sv
  - uart_baud_gen.sv
  - uart_rx.sv
  - uart_tx.sv
  - bip_debug_interface.sv
  - bip_top.sv
  - target: test
    files:
      - tb_bip_top.sv

// File: tb_bip_top.sv
`timescale 1ns/10ps

module tb_bip_top;
    import bip_isa_pkg::*;
    import uart_pkg::*;

    localparam int CLKS_PER_TICK = 2;
    localparam int BIT_CLKS      = 16 * CLKS_PER_TICK;
    localparam int SEED          = 32'hc241_bc33;

    // Run budget from worst case bytes per run, serial time and execution
    localparam int N_RUNS         = 8;
    localparam int MAX_WORDS      = 21;  // 20 instructions and the halt
    localparam int MAX_NOISE      = 8;
    localparam int BYTES_PER_RUN  = MAX_NOISE + 3 + 2 * MAX_WORDS + 6;
    localparam int TIMEOUT_CYCLES = N_RUNS * (BYTES_PER_RUN * 10 * BIT_CLKS + MAX_WORDS + 2)
                                    + 4000;

    localparam int KIND_IMM   = 0;
    localparam int KIND_MIXED = 1;
    localparam int KIND_REUSE = 2;  // Starts by loading data of an earlier run

    logic       i_clk;
    logic       i_reset;
    logic       i_uart_rx;
    logic       o_uart_tx;
    logic [7:0] o_led;

    logic [15:0] prog_q [$];
    logic [15:0] dm_model [int];   // Reference copy of data memory
    bit          addr_known [int]; // Addresses some generated store writes
    int          known_addrs [$];
    logic [15:0] exp_pc;
    logic [15:0] exp_acc;
    logic [15:0] exp_cycles;
    int          test_errors;
    int          tests_run;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count = 0;
    int          k;

    bip_top #(.CLKS_PER_TICK(CLKS_PER_TICK)) uut (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_uart_rx (i_uart_rx),
        .o_uart_tx (o_uart_tx),
        .o_led     (o_led)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Host side of the serial line
    ////////////////////////////////////////////////////////////////////////////
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};  // Stop, data, start
        for (i = 0; i < 10; i++) begin
            @(posedge i_clk);
            #1 i_uart_rx = frame[i];
            repeat (BIT_CLKS - 1) @(posedge i_clk);
        end
    endtask

    task automatic receive_byte(output logic [7:0] b);
        int i;
        @(negedge i_clk);
        while (o_uart_tx !== 1'b0) @(negedge i_clk);
        repeat (BIT_CLKS / 2) @(negedge i_clk);  // Middle of the start bit
        assert (o_uart_tx === 1'b0) else begin
            $display("Start bit of a report byte ended too early at %0t", $time);
            test_errors++;
        end
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge i_clk);
            b[i] = o_uart_tx;  // LSB first
        end
        repeat (BIT_CLKS) @(negedge i_clk);
        assert (o_uart_tx === 1'b1) else begin
            $display("Stop bit of a report byte is missing at %0t", $time);
            test_errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Program generator and ISA model
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_program(input int kind);
        int          n;
        int          i;
        int          pick;
        logic [4:0]  op;
        logic [10:0] field;
        prog_q.delete();
        n = $urandom_range(20, 5);
        for (i = 0; i < n; i++) begin
            field = 11'($urandom_range(2047, 0));
            if (kind == KIND_IMM) begin
                pick = $urandom_range(2, 0);
                op   = (pick == 0) ? OP_LDI : (pick == 1) ? OP_ADDI : OP_SUBI;
            end else begin
                pick = $urandom_range(6, 0);
                case (pick)
                    0:       op = OP_STO;
                    1:       op = OP_LD;
                    2:       op = OP_ADD;
                    3:       op = OP_SUB;
                    4:       op = OP_LDI;
                    5:       op = OP_ADDI;
                    default: op = OP_SUBI;
                endcase
                if (kind == KIND_REUSE && i == 0)
                    op = OP_LD;
                if ((op == OP_LD || op == OP_ADD || op == OP_SUB) && known_addrs.size() == 0)
                    op = OP_STO;  // Nothing written yet
                if (op == OP_LD || op == OP_ADD || op == OP_SUB)
                    field = 11'(known_addrs[$urandom_range(known_addrs.size() - 1, 0)]);
                if (op == OP_STO && !addr_known.exists(int'(field))) begin
                    addr_known[int'(field)] = 1'b1;
                    known_addrs.push_back(int'(field));
                end
            end
            prog_q.push_back({op, field});
        end
        prog_q.push_back({OP_HLT, 11'($urandom_range(2047, 0))});
    endtask

    task automatic model_run();
        int          i;
        logic [4:0]  op;
        logic [10:0] field;
        logic [15:0] imm;
        bit          done;
        exp_acc = 16'h0000;  // CPU leaves reset with a cleared accumulator
        done    = 1'b0;
        for (i = 0; i < prog_q.size() && !done; i++) begin
            op    = prog_q[i][15:11];
            field = prog_q[i][10:0];
            imm   = {{5{field[10]}}, field};
            case (op)
                OP_HLT: begin
                    exp_pc     = 16'(i);
                    exp_cycles = 16'(i + 1);
                    done       = 1'b1;
                end
                OP_STO:  dm_model[int'(field)] = exp_acc;
                OP_LD:   exp_acc = dm_model[int'(field)];
                OP_LDI:  exp_acc = imm;
                OP_ADD:  exp_acc = exp_acc + dm_model[int'(field)];
                OP_ADDI: exp_acc = exp_acc + imm;
                OP_SUB:  exp_acc = exp_acc - dm_model[int'(field)];
                OP_SUBI: exp_acc = exp_acc - imm;
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Command sequences
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_program();
        int i;
        send_byte(CMD_LOAD);
        send_byte(8'(prog_q.size()));
        for (i = 0; i < prog_q.size(); i++) begin
            send_byte(prog_q[i][15:8]);
            send_byte(prog_q[i][7:0]);
        end
    endtask

    task automatic run_and_check();
        logic [47:0] report;
        logic [7:0]  b;
        int          i;
        report = '0;
        fork
            send_byte(CMD_RUN);
            begin
                for (i = 0; i < 6; i++) begin
                    receive_byte(b);
                    report = {report[39:0], b};
                end
            end
        join
        check_value("report pc", exp_pc, report[47:32]);
        check_value("report acc", exp_acc, report[31:16]);
        check_value("report cycles", exp_cycles, report[15:0]);
        check_value("o_led", {8'h00, exp_acc[3:0], exp_pc[3:0]}, {8'h00, o_led});
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL with %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic program_test(input string name, input int kind, input bit noise);
        int         n;
        int         i;
        logic [7:0] b;
        build_program(kind);
        if (noise) begin
            n = $urandom_range(MAX_NOISE, 1);
            for (i = 0; i < n; i++) begin
                b = 8'($urandom_range(255, 0));
                while (b == CMD_LOAD || b == CMD_RUN)
                    b = 8'($urandom_range(255, 0));
                send_byte(b);
            end
        end
        load_program();
        model_run();
        run_and_check();
        finish_test(name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        i_reset      = 1'b1;
        i_uart_rx    = 1'b1;  // Idle line
        test_errors  = 0;
        tests_run    = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        repeat (2) @(posedge i_clk);
        #1 i_reset = 1'b0;

        @(negedge i_clk);
        check_value("o_uart_tx", 16'h0001, {15'h0000, o_uart_tx});
        check_value("o_led", 16'h0000, {8'h00, o_led});
        finish_test("reset state");

        for (k = 0; k < 3; k++)
            program_test("immediate program", KIND_IMM, 1'b0);
        for (k = 0; k < 3; k++)
            program_test("memory program", KIND_MIXED, 1'b0);
        program_test("data kept between runs", KIND_REUSE, 1'b0);
        program_test("stray bytes before load", KIND_MIXED, 1'b1);

        $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_passed,
                 tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: bip_top.sv
`timescale 1ns/10ps

module bip_top #(
    parameter int RAM_DEPTH_PM  = 2048,
    parameter int RAM_DEPTH_DM  = 2048,
    parameter int CLKS_PER_TICK = 651
) (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_uart_rx,
    output logic       o_uart_tx,
    output logic [7:0] o_led
);
    import bip_isa_pkg::*;
    import uart_pkg::*;

    logic                 tick;
    logic                 rx_done;
    logic [NB_DATA-1:0]   rx_data;
    logic                 tx_start;
    logic [NB_DATA-1:0]   tx_data;
    logic                 tx_done;
    logic                 pm_we;
    logic [NB_ADDR-1:0]   pm_waddr;
    logic [RAM_WIDTH-1:0] pm_wdata;
    logic [NB_ADDR-1:0]   pc_fetch;
    bip_instr_u           instr;
    logic [NB_ADDR-1:0]   pc;
    logic [RAM_WIDTH-1:0] acc;
    logic [NB_ADDR-1:0]   dm_addr;
    logic [RAM_WIDTH-1:0] dm_wdata;
    logic [RAM_WIDTH-1:0] dm_rdata;
    logic                 dm_we;
    logic                 halt;
    logic                 cpu_reset;  // From the debug unit
    logic                 cpu_rst;

    assign cpu_rst = i_reset | cpu_reset;

    ////////////////////////////////////////////////////////////////////////////
    // Processor and memories
    ////////////////////////////////////////////////////////////////////////////
    bip_cpu u_cpu (
        .i_clk      (i_clk),
        .i_reset    (cpu_rst),
        .i_instr    (instr),
        .i_dm_data  (dm_rdata),
        .o_pc_fetch (pc_fetch),
        .o_pc       (pc),
        .o_acc      (acc),
        .o_dm_addr  (dm_addr),
        .o_dm_data  (dm_wdata),
        .o_dm_we    (dm_we),
        .o_halt     (halt)
    );

    bip_program_memory #(.RAM_DEPTH(RAM_DEPTH_PM)) u_program_memory (
        .i_clk   (i_clk),
        .i_we    (pm_we),
        .i_waddr (pm_waddr),
        .i_wdata (pm_wdata),
        .i_raddr (pc_fetch),
        .o_data  (instr)
    );

    bip_data_memory #(.RAM_DEPTH(RAM_DEPTH_DM)) u_data_memory (
        .i_clk  (i_clk),
        .i_we   (dm_we),
        .i_addr (dm_addr),
        .i_data (dm_wdata),
        .o_data (dm_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // UART and debug unit
    ////////////////////////////////////////////////////////////////////////////
    uart_baud_gen #(.CLKS_PER_TICK(CLKS_PER_TICK)) u_baud_gen (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx u_uart_rx (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_bit       (i_uart_rx),
        .i_tick      (tick),
        .o_done_data (rx_done),
        .o_data      (rx_data)
    );

    uart_tx u_uart_tx (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_tx_start (tx_start),
        .i_tick     (tick),
        .i_data     (tx_data),
        .o_done_tx  (tx_done),
        .o_tx       (o_uart_tx)
    );

    bip_debug_interface u_debug_interface (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rx_done   (rx_done),
        .i_rx_data   (rx_data),
        .i_tx_done   (tx_done),
        .i_halt      (halt),
        .i_pc        (pc),
        .i_acc       (acc),
        .o_tx_start  (tx_start),
        .o_tx_data   (tx_data),
        .o_pm_we     (pm_we),
        .o_pm_addr   (pm_waddr),
        .o_pm_data   (pm_wdata),
        .o_cpu_reset (cpu_reset)
    );

    // LEDs keep the halt state after the CPU goes back to reset
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_led <= '0;
        end else if (halt) begin
            o_led <= {acc[3:0], pc[3:0]};
        end
    end

endmodule

// File: bip_debug_interface.sv
`timescale 1ns/10ps

module bip_debug_interface (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  logic                               i_rx_done,
    input  logic [uart_pkg::NB_DATA-1:0]       i_rx_data,
    input  logic                               i_tx_done,
    input  logic                               i_halt,
    input  logic [bip_isa_pkg::NB_ADDR-1:0]    i_pc,
    input  logic [bip_isa_pkg::RAM_WIDTH-1:0]  i_acc,
    output logic                               o_tx_start,
    output logic [uart_pkg::NB_DATA-1:0]       o_tx_data,
    output logic                               o_pm_we,
    output logic [bip_isa_pkg::NB_ADDR-1:0]    o_pm_addr,
    output logic [bip_isa_pkg::RAM_WIDTH-1:0]  o_pm_data,
    output logic                               o_cpu_reset
);
    import bip_isa_pkg::*;
    import uart_pkg::*;

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_COUNT  = 3'd1;  // Waiting for word count
    localparam logic [2:0] ST_HIGH   = 3'd2;
    localparam logic [2:0] ST_LOW    = 3'd3;
    localparam logic [2:0] ST_RUN    = 3'd4;
    localparam logic [2:0] ST_REPORT = 3'd5;

    logic [2:0]           state;
    logic [NB_DATA-1:0]   words_left;
    logic [NB_DATA-1:0]   high_byte;
    logic [RAM_WIDTH-1:0] cycles;
    logic [2:0]           byte_idx;     // Report byte 0..5
    logic [RAM_WIDTH-1:0] report_word;

    ////////////////////////////////////////////////////////////////////////////
    // Report byte select for PC, ACC and cycles with the high byte first
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (byte_idx[2:1])
            2'd0:    report_word = RAM_WIDTH'(i_pc);
            2'd1:    report_word = i_acc;
            default: report_word = cycles;
        endcase
    end

    assign o_tx_data  = byte_idx[0] ? report_word[NB_DATA-1:0]
                                    : report_word[RAM_WIDTH-1 -: NB_DATA];
    assign o_tx_start = (state == ST_REPORT) && i_tx_done;

    ////////////////////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= ST_IDLE;
            words_left  <= '0;
            cycles      <= '0;
            byte_idx    <= '0;
            o_pm_we     <= 1'b0;
            o_pm_addr   <= '0;
            o_cpu_reset <= 1'b1;
        end else begin
            o_pm_we <= 1'b0;
            if (o_pm_we) begin
                o_pm_addr <= o_pm_addr + 1'b1;  // Next word slot
            end
            case (state)
                ST_IDLE: begin
                    if (i_rx_done && (i_rx_data == CMD_LOAD)) begin
                        state <= ST_COUNT;
                    end else if (i_rx_done && (i_rx_data == CMD_RUN)) begin
                        state       <= ST_RUN;
                        cycles      <= '0;
                        o_cpu_reset <= 1'b0;
                    end
                end
                ST_COUNT: begin
                    if (i_rx_done) begin
                        words_left <= i_rx_data;
                        o_pm_addr  <= '0;
                        state      <= (i_rx_data == '0) ? ST_IDLE : ST_HIGH;
                    end
                end
                ST_HIGH: begin
                    if (i_rx_done) begin
                        high_byte <= i_rx_data;
                        state     <= ST_LOW;
                    end
                end
                ST_LOW: begin
                    if (i_rx_done) begin
                        o_pm_we    <= 1'b1;
                        o_pm_data  <= {high_byte, i_rx_data};
                        words_left <= words_left - 1'b1;
                        state      <= (words_left == NB_DATA'(1)) ? ST_IDLE : ST_HIGH;
                    end
                end
                ST_RUN: begin
                    if (i_halt) begin
                        state    <= ST_REPORT;
                        byte_idx <= '0;
                    end else begin
                        cycles <= cycles + 1'b1;
                    end
                end
                default: begin
                    if (o_tx_start) begin
                        if (byte_idx == 3'd5) begin
                            state       <= ST_IDLE;
                            o_cpu_reset <= 1'b1;  // CPU back in reset
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Start only reaches an idle transmitter, which takes it at once
    a_start_when_idle : assert property (
        @(posedge i_clk) disable iff (i_reset) o_tx_start |=> !i_tx_done
    );

endmodule

// File: uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_tx_start,
    input  logic                         i_tick,
    input  logic [uart_pkg::NB_DATA-1:0] i_data,
    output logic                         o_done_tx,
    output logic                         o_tx
);
    import uart_pkg::*;

    localparam int NB_NCOUNT = $clog2(NB_DATA);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic [1:0]           state;
    logic [3:0]           s_count;
    logic [NB_NCOUNT-1:0] n_count;
    logic [NB_DATA-1:0]   shift;

    assign o_done_tx = (state == ST_IDLE);  // Idle level

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= ST_IDLE;
            s_count <= '0;
            n_count <= '0;
            o_tx    <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_tx_start) begin
                        state   <= ST_START;
                        s_count <= '0;
                        shift   <= i_data;
                        o_tx    <= 1'b0;
                    end
                end
                ST_START: begin
                    if (i_tick) begin
                        if (s_count == 4'd15) begin
                            state   <= ST_DATA;
                            s_count <= '0;
                            n_count <= '0;
                            o_tx    <= shift[0];
                        end else begin
                            s_count <= s_count + 1'b1;
                        end
                    end
                end
                ST_DATA: begin
                    if (i_tick) begin
                        if (s_count == 4'd15) begin
                            s_count <= '0;
                            shift   <= shift >> 1;
                            if (n_count == NB_NCOUNT'(NB_DATA - 1)) begin
                                state <= ST_STOP;
                                o_tx  <= 1'b1;
                            end else begin
                                n_count <= n_count + 1'b1;
                                o_tx    <= shift[1];  // Next bit after the shift
                            end
                        end else begin
                            s_count <= s_count + 1'b1;
                        end
                    end
                end
                default: begin
                    if (i_tick) begin
                        if (s_count == 4'(SB_TICK - 1)) begin
                            state <= ST_IDLE;
                        end else begin
                            s_count <= s_count + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    a_idle_line_high : assert property (
        @(posedge i_clk) disable iff (i_reset) o_done_tx |-> o_tx
    );

endmodule

// File: uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_bit,
    input  logic                         i_tick,
    output logic                         o_done_data,
    output logic [uart_pkg::NB_DATA-1:0] o_data
);
    import uart_pkg::*;

    localparam int NB_NCOUNT = $clog2(NB_DATA);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic [1:0]           state;
    logic [3:0]           s_count;  // Ticks inside the current bit
    logic [NB_NCOUNT-1:0] n_count;  // Data bits taken so far

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= ST_IDLE;
            s_count     <= '0;
            n_count     <= '0;
            o_done_data <= 1'b0;
        end else begin
            o_done_data <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (!i_bit) begin
                        state   <= ST_START;
                        s_count <= '0;
                    end
                end
                ST_START: begin
                    if (i_tick) begin
                        if (s_count == 4'd7) begin  // Middle of the start bit
                            state   <= ST_DATA;
                            s_count <= '0;
                            n_count <= '0;
                        end else begin
                            s_count <= s_count + 1'b1;
                        end
                    end
                end
                ST_DATA: begin
                    if (i_tick) begin
                        if (s_count == 4'd15) begin
                            s_count <= '0;
                            o_data  <= {i_bit, o_data[NB_DATA-1:1]};  // LSB first
                            if (n_count == NB_NCOUNT'(NB_DATA - 1)) begin
                                state <= ST_STOP;
                            end else begin
                                n_count <= n_count + 1'b1;
                            end
                        end else begin
                            s_count <= s_count + 1'b1;
                        end
                    end
                end
                default: begin
                    if (i_tick) begin
                        if (s_count == 4'(SB_TICK - 1)) begin
                            state       <= ST_IDLE;
                            o_done_data <= 1'b1;
                        end else begin
                            s_count <= s_count + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: uart_baud_gen.sv
`timescale 1ns/10ps

module uart_baud_gen #(
    parameter int CLKS_PER_TICK = 651
) (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick
);
    localparam int NB_COUNT = $clog2(CLKS_PER_TICK);

    logic [NB_COUNT-1:0] count;

    assign o_tick = (count == NB_COUNT'(CLKS_PER_TICK - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset || o_tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// File: bip_data_memory.sv
`timescale 1ns/10ps

module bip_data_memory #(
    parameter int RAM_DEPTH = 2048
) (
    input  logic                               i_clk,
    input  logic                               i_we,
    input  logic [bip_isa_pkg::NB_ADDR-1:0]    i_addr,
    input  logic [bip_isa_pkg::RAM_WIDTH-1:0]  i_data,
    output logic [bip_isa_pkg::RAM_WIDTH-1:0]  o_data
);
    import bip_isa_pkg::*;

    logic [RAM_WIDTH-1:0] ram [RAM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            ram[i_addr] <= i_data;
        end
    end

    assign o_data = ram[i_addr];  // Loads see the word in the same cycle

endmodule

// File: bip_program_memory.sv
`timescale 1ns/10ps

module bip_program_memory #(
    parameter int RAM_DEPTH = 2048
) (
    input  logic                               i_clk,
    input  logic                               i_we,
    input  logic [bip_isa_pkg::NB_ADDR-1:0]    i_waddr,
    input  logic [bip_isa_pkg::RAM_WIDTH-1:0]  i_wdata,
    input  logic [bip_isa_pkg::NB_ADDR-1:0]    i_raddr,
    output logic [bip_isa_pkg::RAM_WIDTH-1:0]  o_data
);
    import bip_isa_pkg::*;

    logic [RAM_WIDTH-1:0] ram [RAM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            ram[i_waddr] <= i_wdata;  // Loader port
        end
        o_data <= ram[i_raddr];       // One cycle fetch latency
    end

endmodule

// File: bip_cpu.sv
`timescale 1ns/10ps

module bip_cpu (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  bip_isa_pkg::bip_instr_u            i_instr,
    input  logic [bip_isa_pkg::RAM_WIDTH-1:0]  i_dm_data,
    output logic [bip_isa_pkg::NB_ADDR-1:0]    o_pc_fetch,
    output logic [bip_isa_pkg::NB_ADDR-1:0]    o_pc,
    output logic [bip_isa_pkg::RAM_WIDTH-1:0]  o_acc,
    output logic [bip_isa_pkg::NB_ADDR-1:0]    o_dm_addr,
    output logic [bip_isa_pkg::RAM_WIDTH-1:0]  o_dm_data,
    output logic                               o_dm_we,
    output logic                               o_halt
);
    import bip_isa_pkg::*;

    logic [NB_ADDR-1:0]   pc_fetch;
    logic                 fetch_valid;  // Low during the first fetch cycle
    logic [NB_OPCODE-1:0] opcode;
    logic                 use_imm;
    logic [RAM_WIDTH-1:0] imm_ext;
    logic [RAM_WIDTH-1:0] operand;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////
    assign opcode  = i_instr.mem.opcode;
    assign imm_ext = {{(RAM_WIDTH-NB_OPERAND){i_instr.imm.value[NB_OPERAND-1]}},
                      i_instr.imm.value};
    assign use_imm = (opcode == OP_LDI) || (opcode == OP_ADDI) || (opcode == OP_SUBI);
    assign operand = use_imm ? imm_ext : i_dm_data;

    assign o_halt    = fetch_valid && (opcode == OP_HLT);
    assign o_dm_we   = fetch_valid && (opcode == OP_STO);
    assign o_dm_addr = i_instr.mem.addr;
    assign o_dm_data = o_acc;

    // While halted the halt word is fetched again, so it stays on the bus
    assign o_pc_fetch = o_halt ? o_pc : pc_fetch;

    ////////////////////////////////////////////////////////////////////////////
    // Program counters and accumulator
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_fetch    <= '0;
            o_pc        <= '0;
            fetch_valid <= 1'b0;
            o_acc       <= '0;
        end else if (!o_halt) begin
            pc_fetch    <= pc_fetch + 1'b1;
            o_pc        <= pc_fetch;        // Address of the word now in flight
            fetch_valid <= 1'b1;
            if (fetch_valid) begin
                case (opcode)
                    OP_LD, OP_LDI:   o_acc <= operand;
                    OP_ADD, OP_ADDI: o_acc <= o_acc + operand;
                    OP_SUB, OP_SUBI: o_acc <= o_acc - operand;
                    default:         o_acc <= o_acc;
                endcase
            end
        end
    end

    // A frozen CPU keeps its state and must leave data memory alone
    a_no_store_on_halt : assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_halt |=> o_halt && !o_dm_we && $stable(o_pc) && $stable(o_acc)
    );

endmodule

// File: uart_pkg.sv
package uart_pkg;

    localparam int NB_DATA = 8;   // Data bits per frame
    localparam int SB_TICK = 16;  // One stop bit

    // Host command bytes
    localparam logic [NB_DATA-1:0] CMD_LOAD = 8'h4C;
    localparam logic [NB_DATA-1:0] CMD_RUN  = 8'h52;

endpackage

// File: bip_isa_pkg.sv
package bip_isa_pkg;

    localparam int NB_OPCODE  = 5;
    localparam int NB_OPERAND = 11;
    localparam int NB_ADDR    = 11;
    localparam int RAM_WIDTH  = 16;

    // Any other opcode runs as a nop
    localparam logic [NB_OPCODE-1:0] OP_HLT  = 5'd0;
    localparam logic [NB_OPCODE-1:0] OP_STO  = 5'd1;
    localparam logic [NB_OPCODE-1:0] OP_LD   = 5'd2;
    localparam logic [NB_OPCODE-1:0] OP_LDI  = 5'd3;
    localparam logic [NB_OPCODE-1:0] OP_ADD  = 5'd4;
    localparam logic [NB_OPCODE-1:0] OP_ADDI = 5'd5;
    localparam logic [NB_OPCODE-1:0] OP_SUB  = 5'd6;
    localparam logic [NB_OPCODE-1:0] OP_SUBI = 5'd7;

    typedef struct packed {
        logic [NB_OPCODE-1:0] opcode;
        logic [NB_ADDR-1:0]   addr;    // Data memory address
    } bip_mem_t;

    typedef struct packed {
        logic [NB_OPCODE-1:0]         opcode;
        logic signed [NB_OPERAND-1:0] value;  // Two's complement immediate
    } bip_imm_t;

    // One instruction word, read as a memory or an immediate form
    typedef union packed {
        bip_mem_t mem;
        bip_imm_t imm;
    } bip_instr_u;

endpackage
